// ==== source/rvPkg.sv ====
`default_nettype none

package rvPkg;

    // base opcodes, bits 6:0 of the instruction
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // class of operation handed to the ALU decoder in EX
    localparam logic [2:0] aluR      = 3'd0;
    localparam logic [2:0] aluI      = 3'd1;
    localparam logic [2:0] aluLoad   = 3'd2;
    localparam logic [2:0] aluStore  = 3'd3;
    localparam logic [2:0] aluBranch = 3'd4;
    localparam logic [2:0] aluJump   = 3'd5; // jal and jalr share it
    localparam logic [2:0] aluLui    = 3'd6;
    localparam logic [2:0] aluAuipc  = 3'd7;

    localparam logic [1:0] resAlu = 2'd0;
    localparam logic [1:0] resMem = 2'd1;
    localparam logic [1:0] resPc4 = 2'd2; // link address

    localparam logic [2:0] immI = 3'd0;
    localparam logic [2:0] immS = 3'd1;
    localparam logic [2:0] immB = 3'd2;
    localparam logic [2:0] immU = 3'd3;
    localparam logic [2:0] immJ = 3'd4;

    localparam logic [2:0] memWord  = 3'd0;
    localparam logic [2:0] memHalf  = 3'd1;
    localparam logic [2:0] memByte  = 3'd2;
    localparam logic [2:0] memByteU = 3'd3;
    localparam logic [2:0] memHalfU = 3'd4;

    localparam logic [31:0] nopInstr = 32'h0000_0013; // addi x0, x0, 0

    // one instruction word, read through whichever format fits the opcode
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrT;

endpackage

`default_nettype wire

// ==== source/control.sv ====
`default_nettype none

module control (
    input  rvPkg::instrT instrD,
    input  logic         stallD,
    output logic         regWriteD,
    output logic [1:0]   resultSrcD,
    output logic         memWriteD,
    output logic         memReadD,
    output logic         loadD,
    output logic         storeD,
    output logic [2:0]   memCtrlD,
    output logic         aluSrcD,
    output logic [2:0]   immSelD,
    output logic [2:0]   aluOpD,
    output logic         jumpD,
    output logic         jalrD,
    output logic         branchD
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instrD.r.opcode;
    assign funct3 = instrD.r.funct3; // same bits in every view that has it

    always_comb begin
        regWriteD  = 1'b0;
        resultSrcD = rvPkg::resAlu;
        memWriteD  = 1'b0;
        memReadD   = 1'b0;
        loadD      = 1'b0;
        storeD     = 1'b0;
        memCtrlD   = rvPkg::memWord;
        aluSrcD    = 1'b0;
        immSelD    = rvPkg::immI;
        aluOpD     = rvPkg::aluR;
        jumpD      = 1'b0;
        jalrD      = 1'b0;
        branchD    = 1'b0;

        case (opcode)
            rvPkg::opR: begin
                aluOpD    = rvPkg::aluR;
                regWriteD = 1'b1;
            end
            rvPkg::opI: begin
                aluOpD    = rvPkg::aluI;
                aluSrcD   = 1'b1;
                regWriteD = 1'b1;
            end
            rvPkg::opLoad: begin
                aluOpD     = rvPkg::aluLoad;
                aluSrcD    = 1'b1;
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resMem;
                memReadD   = 1'b1;
                loadD      = 1'b1;
                case (funct3)
                    3'b000:  memCtrlD = rvPkg::memByte;  // lb
                    3'b001:  memCtrlD = rvPkg::memHalf;  // lh
                    3'b010:  memCtrlD = rvPkg::memWord;  // lw
                    3'b100:  memCtrlD = rvPkg::memByteU; // lbu
                    3'b101:  memCtrlD = rvPkg::memHalfU; // lhu
                    default: begin
                        memReadD = 1'b0; // unknown width, no memory access
                        loadD    = 1'b0;
                    end
                endcase
            end
            rvPkg::opStore: begin
                aluOpD    = rvPkg::aluStore;
                aluSrcD   = 1'b1;
                immSelD   = rvPkg::immS;
                memWriteD = 1'b1;
                storeD    = 1'b1;
                case (funct3)
                    3'b000:  memCtrlD = rvPkg::memByte; // sb
                    3'b001:  memCtrlD = rvPkg::memHalf; // sh
                    3'b010:  memCtrlD = rvPkg::memWord; // sw
                    default: storeD = 1'b0;
                endcase
            end
            rvPkg::opBranch: begin
                aluOpD  = rvPkg::aluBranch;
                immSelD = rvPkg::immB;
                branchD = 1'b1; // both operands from registers
            end
            rvPkg::opJal: begin
                aluOpD     = rvPkg::aluJump;
                aluSrcD    = 1'b1;
                immSelD    = rvPkg::immJ;
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resPc4;
                jumpD      = 1'b1;
            end
            rvPkg::opJalr: begin
                aluOpD     = rvPkg::aluJump;
                aluSrcD    = 1'b1;
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resPc4;
                jumpD      = 1'b1;
                jalrD      = 1'b1; // target comes from rs1, not pc
            end
            rvPkg::opLui: begin
                aluOpD    = rvPkg::aluLui;
                aluSrcD   = 1'b1;
                immSelD   = rvPkg::immU;
                regWriteD = 1'b1;
            end
            rvPkg::opAuipc: begin
                aluOpD    = rvPkg::aluAuipc;
                aluSrcD   = 1'b1;
                immSelD   = rvPkg::immU;
                regWriteD = 1'b1;
            end
            default: aluOpD = rvPkg::aluR; // unknown opcode decodes as a no-op
        endcase

        // a stalled instruction goes down the pipe as a bubble
        if (stallD) begin
            regWriteD = 1'b0;
            memWriteD = 1'b0;
            memReadD  = 1'b0;
            loadD     = 1'b0;
            storeD    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/immGen.sv ====
`default_nettype none

module immGen (
    input  rvPkg::instrT instrD,
    input  logic [2:0]   immSelD,
    output logic [31:0]  immD
);

    always_comb begin
        case (immSelD)
            rvPkg::immS: begin
                immD = {{20{instrD.s.immHi[6]}}, instrD.s.immHi, instrD.s.immLo};
            end
            rvPkg::immB: begin
                immD = {{19{instrD.b.imm12}},
                        instrD.b.imm12,
                        instrD.b.imm11,
                        instrD.b.imm10to5,
                        instrD.b.imm4to1,
                        1'b0};                    // halfword aligned
            end
            rvPkg::immU: begin
                immD = {instrD.u.imm31to12, 12'b0}; // upper 20 bits only
            end
            rvPkg::immJ: begin
                immD = {{11{instrD.j.imm20}},
                        instrD.j.imm20,
                        instrD.j.imm19to12,
                        instrD.j.imm11,
                        instrD.j.imm10to1,
                        1'b0};
            end
            default: begin
                immD = {{20{instrD.i.imm[11]}}, instrD.i.imm}; // I format
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        wbEn,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= 32'd0;
            end
        end else if (wbEn && wbRd != 5'd0) begin
            regs[wbRd] <= wbData;
        end
    end

    // writeback lands in the same cycle as the read
    always_comb begin
        if (rs1 == 5'd0)                 rd1 = 32'd0;
        else if (wbEn && wbRd == rs1)    rd1 = wbData;
        else                             rd1 = regs[rs1];

        if (rs2 == 5'd0)                 rd2 = 32'd0;
        else if (wbEn && wbRd == rs2)    rd2 = wbData;
        else                             rd2 = regs[rs2];
    end

    // a stored value comes back from storage on the next read
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(rstN) && $past(wbEn) && $past(wbRd) != 5'd0
            && rs1 == $past(wbRd) && !(wbEn && wbRd == rs1))
            |-> rd1 == $past(wbData))
        else $error("regFile: written value not read back");

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
    input  rvPkg::instrT instrD,
    input  logic         loadE,
    input  logic [4:0]   rdE,
    output logic         stallD
);

    logic [6:0] opcode;
    logic       useRs1;
    logic       useRs2;
    logic       hitRs1;
    logic       hitRs2;

    assign opcode = instrD.r.opcode;

    // only formats that really read a register field may cause a stall
    assign useRs2 = (opcode == rvPkg::opR)
                 || (opcode == rvPkg::opStore)
                 || (opcode == rvPkg::opBranch);
    assign useRs1 = !((opcode == rvPkg::opLui)
                   || (opcode == rvPkg::opAuipc)
                   || (opcode == rvPkg::opJal));

    assign hitRs1 = useRs1 && (rdE == instrD.r.rs1);
    assign hitRs2 = useRs2 && (rdE == instrD.r.rs2);

    // load result is not ready until after MEM
    assign stallD = loadE && (rdE != 5'd0) && (hitRs1 || hitRs2);

endmodule

`default_nettype wire

// ==== source/decodePipeRegs.sv ====
`default_nettype none

module decodePipeRegs (
    input  logic         clk,
    input  logic         rstN,
    input  logic [31:0]  instrF,
    input  logic [31:0]  pcF,
    input  logic         stallD,
    input  logic         regWriteD,
    input  logic [1:0]   resultSrcD,
    input  logic         memWriteD,
    input  logic         memReadD,
    input  logic         loadD,
    input  logic         storeD,
    input  logic [2:0]   memCtrlD,
    input  logic         aluSrcD,
    input  logic [2:0]   aluOpD,
    input  logic         jumpD,
    input  logic         jalrD,
    input  logic         branchD,
    input  logic [31:0]  immD,
    input  logic [31:0]  rd1D,
    input  logic [31:0]  rd2D,
    output rvPkg::instrT instrD,
    output logic [31:0]  pcD,
    output logic         regWriteE,
    output logic [1:0]   resultSrcE,
    output logic         memWriteE,
    output logic         memReadE,
    output logic         loadE,
    output logic         storeE,
    output logic [2:0]   memCtrlE,
    output logic         aluSrcE,
    output logic [2:0]   aluOpE,
    output logic         jumpE,
    output logic         jalrE,
    output logic         branchE,
    output logic [31:0]  rd1E,
    output logic [31:0]  rd2E,
    output logic [31:0]  immE,
    output logic [4:0]   rdE,
    output logic [4:0]   rs1E,
    output logic [4:0]   rs2E,
    output logic [31:0]  pcE
);

    // IF/ID
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= rvPkg::nopInstr;
            pcD    <= 32'd0;
        end else if (!stallD) begin
            instrD <= instrF;
            pcD    <= pcF;
        end
    end

    // ID/EX, bubble comes in through the zeroed enables from control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE  <= 1'b0;
            resultSrcE <= 2'd0;
            memWriteE  <= 1'b0;
            memReadE   <= 1'b0;
            loadE      <= 1'b0;
            storeE     <= 1'b0;
            memCtrlE   <= 3'd0;
            aluSrcE    <= 1'b0;
            aluOpE     <= 3'd0;
            jumpE      <= 1'b0;
            jalrE      <= 1'b0;
            branchE    <= 1'b0;
            rd1E       <= 32'd0;
            rd2E       <= 32'd0;
            immE       <= 32'd0;
            rdE        <= 5'd0;
            rs1E       <= 5'd0;
            rs2E       <= 5'd0;
            pcE        <= 32'd0;
        end else begin
            regWriteE  <= regWriteD;
            resultSrcE <= resultSrcD;
            memWriteE  <= memWriteD;
            memReadE   <= memReadD;
            loadE      <= loadD;
            storeE     <= storeD;
            memCtrlE   <= memCtrlD;
            aluSrcE    <= aluSrcD;
            aluOpE     <= aluOpD;
            jumpE      <= jumpD;
            jalrE      <= jalrD;
            branchE    <= branchD;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            immE       <= immD;
            rdE        <= instrD.r.rd;
            rs1E       <= instrD.r.rs1;
            rs2E       <= instrD.r.rs2;
            pcE        <= pcD;
        end
    end

    // the bubble carries loadE low, so the hazard clears on the next cycle
    assert property (@(posedge clk) disable iff (!rstN) stallD |=> !stallD)
        else $error("decodePipeRegs: stall held for two cycles");

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
`default_nettype none

module decodeStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instrF,
    input  logic [31:0] pcF,
    input  logic        wbEn,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    output logic        stallD,
    output logic        regWriteE,
    output logic [1:0]  resultSrcE,
    output logic        memWriteE,
    output logic        memReadE,
    output logic        loadE,
    output logic        storeE,
    output logic [2:0]  memCtrlE,
    output logic        aluSrcE,
    output logic [2:0]  aluOpE,
    output logic        jumpE,
    output logic        jalrE,
    output logic        branchE,
    output logic [31:0] rd1E,
    output logic [31:0] rd2E,
    output logic [31:0] immE,
    output logic [4:0]  rdE,
    output logic [4:0]  rs1E,
    output logic [4:0]  rs2E,
    output logic [31:0] pcE
);

    rvPkg::instrT instrD;
    logic [31:0]  pcD;
    logic         regWriteD;
    logic [1:0]   resultSrcD;
    logic         memWriteD;
    logic         memReadD;
    logic         loadD;
    logic         storeD;
    logic [2:0]   memCtrlD;
    logic         aluSrcD;
    logic [2:0]   immSelD;
    logic [2:0]   aluOpD;
    logic         jumpD;
    logic         jalrD;
    logic         branchD;
    logic [31:0]  immD;
    logic [31:0]  rd1D;
    logic [31:0]  rd2D;

    decodePipeRegs pipeRegs_i (
        .clk, .rstN, .instrF, .pcF, .stallD,
        .regWriteD, .resultSrcD, .memWriteD, .memReadD, .loadD, .storeD,
        .memCtrlD, .aluSrcD, .aluOpD, .jumpD, .jalrD, .branchD,
        .immD, .rd1D, .rd2D,
        .instrD, .pcD,
        .regWriteE, .resultSrcE, .memWriteE, .memReadE, .loadE, .storeE,
        .memCtrlE, .aluSrcE, .aluOpE, .jumpE, .jalrE, .branchE,
        .rd1E, .rd2E, .immE, .rdE, .rs1E, .rs2E, .pcE
    );

    control control_i (
        .instrD, .stallD,
        .regWriteD, .resultSrcD, .memWriteD, .memReadD, .loadD, .storeD,
        .memCtrlD, .aluSrcD, .immSelD, .aluOpD, .jumpD, .jalrD, .branchD
    );

    immGen immGen_i (
        .instrD, .immSelD, .immD
    );

    regFile regFile_i (
        .clk, .rstN,
        .rs1    (instrD.r.rs1),
        .rs2    (instrD.r.rs2),
        .wbEn, .wbRd, .wbData,
        .rd1    (rd1D),
        .rd2    (rd2D)
    );

    hazardUnit hazardUnit_i (
        .instrD, .loadE, .rdE, .stallD
    );

endmodule

`default_nettype wire

// ==== verification/decodeStageTb.sv ====
`default_nettype none

module decodeStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rstN;
    logic [31:0] instrF;
    logic [31:0] pcF;
    logic        wbEn;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        stallD;
    logic        regWriteE;
    logic [1:0]  resultSrcE;
    logic        memWriteE;
    logic        memReadE;
    logic        loadE;
    logic        storeE;
    logic [2:0]  memCtrlE;
    logic        aluSrcE;
    logic [2:0]  aluOpE;
    logic        jumpE;
    logic        jalrE;
    logic        branchE;
    logic [31:0] rd1E;
    logic [31:0] rd2E;
    logic [31:0] immE;
    logic [4:0]  rdE;
    logic [4:0]  rs1E;
    logic [4:0]  rs2E;
    logic [31:0] pcE;

    // reference model state
    logic [31:0] mRegs [32];
    logic [31:0] mInstrD;
    logic [31:0] mPcD;
    logic [16:0] mCtrlE; // {regWrite, resultSrc, memWrite, memRead, load, store, ...}
    logic [31:0] mRd1E;
    logic [31:0] mRd2E;
    logic [31:0] mImmE;
    logic [4:0]  mRdE;
    logic [4:0]  mRs1E;
    logic [4:0]  mRs2E;
    logic [31:0] mPcE;
    logic        mStall;
    logic [31:0] nextPc;

    localparam logic [16:0] enableBits = 17'h13c00; // regWrite, memWrite, memRead, load, store

    int errors;
    int checks;
    int testErrors;
    int testChecks;
    int tests;

    decodeStage decodeStage_i (.*);

    always #20 clk = ~clk;

    task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        testChecks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [16:0] dutCtrl();
        return {regWriteE, resultSrcE, memWriteE, memReadE, loadE, storeE, memCtrlE,
                aluSrcE, aluOpE, jumpE, jalrE, branchE};
    endfunction

    // control table as the ISA defines the classes
    function automatic logic [16:0] decodeCtrl(input logic [31:0] ins);
        logic       regW, memW, memR, ld, st, aSrc, jmp, jr, br;
        logic [1:0] res;
        logic [2:0] mc;
        logic [2:0] op;
        {regW, memW, memR, ld, st, aSrc, jmp, jr, br} = '0;
        res = rvPkg::resAlu;
        mc  = rvPkg::memWord;
        op  = rvPkg::aluR;
        case (ins[6:0])
            rvPkg::opR: regW = 1'b1;
            rvPkg::opI: begin
                {regW, aSrc} = 2'b11;
                op = rvPkg::aluI;
            end
            rvPkg::opLoad: begin
                {regW, aSrc, memR, ld} = 4'b1111;
                res = rvPkg::resMem;
                op  = rvPkg::aluLoad;
                case (ins[14:12])
                    3'b000:  mc = rvPkg::memByte;
                    3'b001:  mc = rvPkg::memHalf;
                    3'b100:  mc = rvPkg::memByteU;
                    3'b101:  mc = rvPkg::memHalfU;
                    default: mc = rvPkg::memWord;
                endcase
            end
            rvPkg::opStore: begin
                {memW, st, aSrc} = 3'b111;
                op = rvPkg::aluStore;
                mc = (ins[14:12] == 3'b000) ? rvPkg::memByte :
                     (ins[14:12] == 3'b001) ? rvPkg::memHalf : rvPkg::memWord;
            end
            rvPkg::opBranch: begin
                br = 1'b1;
                op = rvPkg::aluBranch;
            end
            rvPkg::opJal, rvPkg::opJalr: begin
                {regW, aSrc, jmp} = 3'b111;
                jr  = (ins[6:0] == rvPkg::opJalr);
                res = rvPkg::resPc4;
                op  = rvPkg::aluJump;
            end
            rvPkg::opLui, rvPkg::opAuipc: begin
                {regW, aSrc} = 2'b11;
                op = (ins[6:0] == rvPkg::opLui) ? rvPkg::aluLui : rvPkg::aluAuipc;
            end
            default: regW = 1'b0;
        endcase
        return {regW, res, memW, memR, ld, st, mc, aSrc, op, jmp, jr, br};
    endfunction

    function automatic logic [31:0] expImm(input logic [31:0] i);
        case (i[6:0])
            rvPkg::opStore:  return {{20{i[31]}}, i[31:25], i[11:7]};
            rvPkg::opBranch: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            rvPkg::opLui,
            rvPkg::opAuipc:  return {i[31:12], 12'b0};
            rvPkg::opJal:    return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:         return {{20{i[31]}}, i[31:20]};
        endcase
    endfunction

    function automatic logic stallFor(input logic [31:0] ins, input logic ldE,
                                      input logic [4:0] rd);
        logic [6:0] op;
        logic       readsRs1;
        logic       readsRs2;
        op = ins[6:0];
        readsRs2 = (op == rvPkg::opR) || (op == rvPkg::opStore) || (op == rvPkg::opBranch);
        readsRs1 = (op != rvPkg::opLui) && (op != rvPkg::opAuipc) && (op != rvPkg::opJal);
        return ldE && (rd != 5'd0)
            && ((readsRs1 && rd == ins[19:15]) || (readsRs2 && rd == ins[24:20]));
    endfunction

    function automatic logic [31:0] readReg(input logic [4:0] r);
        if (r == 5'd0)
            return 32'd0;
        if (wbEn && wbRd == r)
            return wbData; // write-through
        return mRegs[r];
    endfunction

    // legal encoding of one of the nine opcode classes, other fields random
    function automatic logic [31:0] randInstr(input int kind);
        logic [31:0] w;
        logic [2:0]  f3;
        w  = $urandom;
        f3 = w[14:12];
        case (kind)
            0: begin
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
                w[6:0]   = rvPkg::opR;
            end
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    w[31:25] = (f3 == 3'd5 && w[30]) ? 7'h20 : 7'h00; // shift amounts
                w[6:0] = rvPkg::opI;
            end
            2: begin
                f3     = (w[13:12] == 2'd3) ? 3'b100 : {1'b0, w[13:12]};
                f3     = (f3 == 3'b000 && w[15]) ? 3'b101 : f3;
                w[6:0] = rvPkg::opLoad;
            end
            3: begin
                f3     = (w[13:12] == 2'd3) ? 3'b010 : {1'b0, w[13:12]};
                w[6:0] = rvPkg::opStore;
            end
            4: begin
                f3     = (f3 == 3'd2 || f3 == 3'd3) ? (f3 | 3'b100) : f3;
                w[6:0] = rvPkg::opBranch;
            end
            5: w[6:0] = rvPkg::opJal;
            6: begin
                f3     = 3'b000;
                w[6:0] = rvPkg::opJalr;
            end
            7: w[6:0] = rvPkg::opLui;
            default: w[6:0] = rvPkg::opAuipc;
        endcase
        if (kind >= 1 && kind <= 6 && kind != 5)
            w[14:12] = f3;
        return w;
    endfunction

    // one clock edge of the reference model, using the inputs held before the edge
    task automatic updateModel();
        logic [31:0] d;
        logic        stall;
        d     = mInstrD;
        stall = stallFor(d, mCtrlE[11], mRdE);
        mRd1E = readReg(d[19:15]);
        mRd2E = readReg(d[24:20]);
        mCtrlE = stall ? (decodeCtrl(d) & ~enableBits) : decodeCtrl(d);
        mImmE = expImm(d);
        mRdE  = d[11:7];
        mRs1E = d[19:15];
        mRs2E = d[24:20];
        mPcE  = mPcD;
        if (wbEn && wbRd != 5'd0)
            mRegs[wbRd] = wbData;
        if (!stall) begin
            mInstrD = instrF;
            mPcD    = pcF;
        end
        mStall = stallFor(mInstrD, mCtrlE[11], mRdE);
    endtask

    task automatic checkOutputs();
        checkVal("stallD", 32'(stallD), 32'(mStall));
        checkVal("control fields", 32'(dutCtrl()), 32'(mCtrlE));
        checkVal("rd1E", rd1E, mRd1E);
        checkVal("rd2E", rd2E, mRd2E);
        checkVal("immE", immE, mImmE);
        checkVal("rdE", 32'(rdE), 32'(mRdE));
        checkVal("rs1E", 32'(rs1E), 32'(mRs1E));
        checkVal("rs2E", 32'(rs2E), 32'(mRs2E));
        checkVal("pcE", pcE, mPcE);
    endtask

    task automatic cycle(input logic [31:0] ins, input logic en, input logic [4:0] rd,
                         input logic [31:0] data);
        @(posedge clk);
        updateModel();
        if (!mStall) begin // upstream holds while decode is stalled
            instrF <= ins;
            pcF    <= nextPc;
            nextPc = nextPc + 32'd4;
        end
        wbEn   <= en;
        wbRd   <= rd;
        wbData <= data;
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("%s: %0d checks, %0d errors", name, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic loadUse(input logic dependent);
        logic [31:0] tmp;
        logic [4:0]  r;
        logic [31:0] user;
        int          waited;
        int          stalls;
        tmp  = $urandom;
        r    = (tmp[4:0] == 5'd0) ? 5'd7 : tmp[4:0];
        user = dependent ? {7'h00, 5'd3, r, 3'b000, 5'd9, rvPkg::opR}
                         : {7'h00, r ^ 5'd2, r ^ 5'd1, 3'b000, 5'd9, rvPkg::opR};
        cycle(rvPkg::nopInstr, 1'b0, 5'd0, 32'd0); // a stall left from earlier traffic clears
        cycle({12'h010, 5'd2, 3'b010, r, rvPkg::opLoad}, 1'b0, 5'd0, 32'd0); // lw r, 16(x2)
        cycle(user, 1'b0, 5'd0, 32'd0);
        if (dependent) begin
            waited = 0;
            while (!stallD && waited < 4) begin
                cycle(rvPkg::nopInstr, 1'b0, 5'd0, 32'd0);
                waited++;
            end
            if (!stallD) begin
                errors++;
                testErrors++;
                $display("stall never rose after a load with a dependent follower");
            end
            checkVal("loadE during stall", 32'(loadE), 32'd1);
            cycle(rvPkg::nopInstr, 1'b0, 5'd0, 32'd0);
            checkVal("stallD after one cycle", 32'(stallD), 32'd0);
            checkVal("bubble enables", 32'({regWriteE, memWriteE, memReadE, loadE, storeE}),
                     32'd0);
            checkVal("bubble rs1E", 32'(rs1E), 32'(r));
            cycle(rvPkg::nopInstr, 1'b0, 5'd0, 32'd0);
            checkVal("held add regWriteE", 32'(regWriteE), 32'd1);
            checkVal("held add rdE", 32'(rdE), 32'd9);
        end else begin
            stalls = 0;
            for (int k = 0; k < 4; k++) begin
                cycle(rvPkg::nopInstr, 1'b0, 5'd0, 32'd0);
                stalls += int'(stallD);
            end
            checkVal("stalls after independent follower", 32'(stalls), 32'd0);
        end
    endtask

    initial begin
        logic [31:0] tmp;
        logic [31:0] ins;
        logic [31:0] dNext;
        logic [4:0]  rd;
        void'($urandom(32'hbbe6_3bbc));
        clk    = 1'b0;
        rstN   <= 1'b0;
        instrF <= rvPkg::nopInstr;
        pcF    <= 32'd0;
        wbEn   <= 1'b0;
        wbRd   <= 5'd0;
        wbData <= 32'd0;
        {errors, checks, testErrors, testChecks, tests} = '0;
        for (int k = 0; k < 32; k++)
            mRegs[k] = 32'd0;
        mInstrD = rvPkg::nopInstr;
        {mPcD, mCtrlE, mRd1E, mRd2E, mImmE, mRdE, mRs1E, mRs2E, mPcE, mStall} = '0;
        nextPc = 32'h0000_0100;

        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkVal("stallD after reset", 32'(stallD), 32'd0);
        checkVal("control after reset", 32'(dutCtrl()), 32'd0);
        checkVal("rd1E after reset", rd1E, 32'd0);
        checkVal("rd2E after reset", rd2E, 32'd0);
        endTest("reset");

        for (int n = 0; n < 300; n++)
            cycle(randInstr($urandom_range(8, 0)), 1'b0, 5'd0, 32'd0);
        endTest("control decode");

        for (int n = 0; n < 200; n++)
            cycle(randInstr($urandom_range(8, 1)), 1'b0, 5'd0, 32'd0);
        endTest("immediates");

        for (int n = 0; n < 300; n++) begin
            ins = randInstr($urandom_range(8, 0));
            ins[24:23] = 2'b00; // x0..x7 keeps reads and writes colliding
            ins[19:18] = 2'b00;
            ins[11:10] = 2'b00;
            dNext = mStall ? mInstrD : instrF; // in decode while this write is driven
            tmp = $urandom;
            case (tmp[4:2])
                3'd0:       rd = 5'd0;
                3'd1, 3'd2: rd = dNext[19:15];
                3'd3:       rd = dNext[24:20];
                default:    rd = {2'b00, tmp[7:5]};
            endcase
            cycle(ins, tmp[0] | tmp[1], rd, $urandom);
        end
        endTest("writeback and bypass");

        for (int n = 0; n < 8; n++)
            loadUse(n[0]);
        endTest("load-use stall");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/rvPkg.sv
source/control.sv
source/immGen.sv
source/regFile.sv
source/hazardUnit.sv
source/decodePipeRegs.sv
source/decodeStage.sv
verification/decodeStageTb.sv

// ==== Makefile ====
TOP := decodeStageTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
